//--- filelist.f
source/core_pkg.sv
source/alu.sv
source/id_stage.sv
source/ex_stage.sv
source/data_ram.sv
source/mem_stage.sv
source/wb_stage.sv
source/core_slice_top.sv
sim/tb_core_slice.sv

//--- run_sim.sh
#!/bin/sh
# build and run the core slice testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f filelist.f \
    --top-module tb_core_slice -o tb_core_slice
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_core_slice > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "tests failed" sim.log; then
    exit 1
fi
exit 0

//--- sim/tb_core_slice.sv
`timescale 1ns/1ps
module tb_core_slice import core_pkg::*; ();

    localparam int OFFER_TIMEOUT = 200;   // covers a full multiply ahead
    localparam int DRAIN_TIMEOUT = 1000;

    typedef struct packed {
        word_t     pc;
        logic      we;
        reg_addr_t waddr;
        word_t     wdata;
        logic      ale;
    } trace_t;

    logic        clk;
    logic        resetn;
    logic        inst_valid;
    word_t       inst;
    word_t       inst_pc;
    logic        inst_allowin;
    logic [63:0] counter;
    logic        wb_valid;
    word_t       wb_pc;
    logic        wb_rf_we;
    reg_addr_t   wb_rf_waddr;
    word_t       wb_rf_wdata;
    logic        wb_excep_ale;

    int          seed;
    int          mismatches;
    int          timeouts;
    logic        aborted;
    word_t       next_pc;
    word_t       ref_rf [32];
    logic [7:0]  ref_mem [4096];   // byte image of the 1024-word RAM
    trace_t      exp_q [$];

    core_slice_top #(.RAM_WORDS(1024)) dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic word_t three_reg_inst(logic [16:0] op, reg_addr_t rd, reg_addr_t rj,
                                             reg_addr_t rk);
        return {op, rk, rj, rd};
    endfunction

    function automatic word_t reg_imm_inst(logic [9:0] op, reg_addr_t rd, reg_addr_t rj,
                                           logic [11:0] imm);
        return {op, imm, rj, rd};
    endfunction

    function automatic word_t counter_inst(logic [21:0] op, reg_addr_t rd);
        return {op, 5'd0, rd};
    endfunction

    function automatic reg_addr_t random_reg();
        return reg_addr_t'(1 + $unsigned($random(seed)) % 29);   // keeps r30 as base
    endfunction

    // executes one instruction on the model state and returns its retire entry
    function automatic trace_t predict_retire(word_t pc, word_t ins);
        trace_t     t;
        reg_addr_t  rd;
        word_t      a, b, imm, addr, res;
        logic [9:0] op12;
        int         size;
        logic       sext, store;
        rd    = ins[4:0];
        a     = ref_rf[ins[9:5]];
        b     = ref_rf[ins[14:10]];
        imm   = {{20{ins[21]}}, ins[21:10]};
        addr  = a + imm;
        op12  = ins[31:22];
        res   = '0;
        size  = 0;
        sext  = (op12 == OP_LD_B || op12 == OP_LD_H);
        store = (op12 == OP_ST_B || op12 == OP_ST_H || op12 == OP_ST_W);
        if (op12 == OP_LD_B || op12 == OP_LD_BU || op12 == OP_ST_B) begin
            size = 1;
        end else if (op12 == OP_LD_H || op12 == OP_LD_HU || op12 == OP_ST_H) begin
            size = 2;
        end else if (op12 == OP_LD_W || op12 == OP_ST_W) begin
            size = 4;
        end
        t.pc    = pc;
        t.we    = 1'b1;
        t.waddr = rd;
        t.ale   = 1'b0;
        if (ins[31:15] == OP_ADD_W) begin
            res = a + b;
        end else if (ins[31:15] == OP_SUB_W) begin
            res = a - b;
        end else if (ins[31:15] == OP_SLT) begin
            res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        end else if (ins[31:15] == OP_AND) begin
            res = a & b;
        end else if (ins[31:15] == OP_OR) begin
            res = a | b;
        end else if (ins[31:15] == OP_MUL_W) begin
            res = a * b;   // low half only
        end else if (op12 == OP_ADDI_W) begin
            res = a + imm;
        end else if (ins[31:10] == OP_RDCNTVL_W) begin
            res = counter[31:0];
        end else if (ins[31:10] == OP_RDCNTVH_W) begin
            res = counter[63:32];
        end else if ((size == 2 && addr[0]) || (size == 4 && addr[1:0] != 2'b00)) begin
            t.ale = 1'b1;   // no access and no write
            t.we  = 1'b0;
        end else if (store) begin
            t.we = 1'b0;
            for (int i = 0; i < size; i++) begin
                ref_mem[int'(addr[11:0]) + i] = ref_rf[rd][8*i +: 8];
            end
        end else begin
            for (int i = 0; i < size; i++) begin
                res[8*i +: 8] = ref_mem[int'(addr[11:0]) + i];
            end
            if (sext && size == 1) begin
                res = {{24{res[7]}}, res[7:0]};
            end else if (sext && size == 2) begin
                res = {{16{res[15]}}, res[15:0]};
            end
        end
        t.wdata = res;
        if (t.we && rd != 5'd0) begin
            ref_rf[rd] = res;
        end
        return t;
    endfunction

    task automatic issue_inst(word_t ins);
        int   waited;
        logic taken;
        if (aborted) begin
            return;
        end
        exp_q.push_back(predict_retire(next_pc, ins));
        inst_valid = 1'b1;
        inst       = ins;
        inst_pc    = next_pc;
        waited     = 0;
        taken      = 1'b0;
        while (!taken && waited < OFFER_TIMEOUT) begin
            @(negedge clk);
            taken = inst_allowin;   // transfer on the coming edge
            @(posedge clk);
            #1;
            waited++;
        end
        inst_valid = 1'b0;
        next_pc    = next_pc + 32'd4;
        if (!taken) begin
            timeouts++;
            aborted = 1'b1;
            $display("instruction at pc %h was never accepted by decode", inst_pc);
        end
    endtask

    task automatic random_alu_op(reg_addr_t rd, reg_addr_t rj, reg_addr_t rk);
        case ($unsigned($random(seed)) % 6)
            0: issue_inst(three_reg_inst(OP_ADD_W, rd, rj, rk));
            1: issue_inst(three_reg_inst(OP_SUB_W, rd, rj, rk));
            2: issue_inst(three_reg_inst(OP_SLT, rd, rj, rk));
            3: issue_inst(three_reg_inst(OP_AND, rd, rj, rk));
            4: issue_inst(three_reg_inst(OP_OR, rd, rj, rk));
            default: issue_inst(reg_imm_inst(OP_ADDI_W, rd, rj, 12'($random(seed))));
        endcase
    endtask

    task automatic wait_drain();
        int waited;
        if (aborted) begin
            return;
        end
        waited = 0;
        while (exp_q.size() != 0 && waited < DRAIN_TIMEOUT) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (exp_q.size() != 0) begin
            timeouts++;
            aborted = 1'b1;
            $display("%0d instructions never retired", exp_q.size());
        end
    endtask

    task automatic show_mismatch(string name, word_t got, word_t expected);
        mismatches++;
        $display("Error at %0d ns: %s got %h, expected %h", $time, name, got, expected);
    endtask

    initial begin : trace_check
        trace_t e;
        forever begin
            @(negedge clk);   // trace is stable mid cycle
            if (resetn && wb_valid) begin
                assert (exp_q.size() > 0) else begin
                    mismatches++;
                    $display("Error at %0d ns: pc %h retired with nothing left to expect",
                             $time, wb_pc);
                end
                if (exp_q.size() > 0) begin
                    e = exp_q.pop_front();
                    assert (wb_pc == e.pc) else show_mismatch("wb_pc", wb_pc, e.pc);
                    assert (wb_rf_we == e.we)
                        else show_mismatch("wb_rf_we", 32'(wb_rf_we), 32'(e.we));
                    assert (wb_excep_ale == e.ale)
                        else show_mismatch("wb_excep_ale", 32'(wb_excep_ale), 32'(e.ale));
                    if (e.we) begin
                        assert (wb_rf_waddr == e.waddr)
                            else show_mismatch("wb_rf_waddr", 32'(wb_rf_waddr), 32'(e.waddr));
                        assert (wb_rf_wdata == e.wdata)
                            else show_mismatch("wb_rf_wdata", wb_rf_wdata, e.wdata);
                    end
                end
            end
        end
    end

    initial begin : program_run
        word_t       base;
        logic [11:0] w, off;
        reg_addr_t   rd, prev;
        seed       = 32'h873f_dfcb;
        mismatches = 0;
        timeouts   = 0;
        aborted    = 1'b0;
        next_pc    = 32'h1c00_0000;
        inst_valid = 1'b0;
        inst       = '0;
        inst_pc    = '0;
        counter    = {$random(seed), $random(seed)};
        for (int r = 0; r < 32; r++) begin
            ref_rf[r] = '0;
        end
        resetn = 1'b0;
        repeat (10) @(posedge clk);
        #1;
        resetn = 1'b1;

        // every register gets a known value first
        for (int r = 1; r < 32; r++) begin
            issue_inst(reg_imm_inst(OP_ADDI_W, reg_addr_t'(r), 5'd0, 12'($random(seed))));
        end
        repeat (40) begin
            random_alu_op(reg_addr_t'($random(seed)), reg_addr_t'($random(seed)),
                          reg_addr_t'($random(seed)));
        end
        issue_inst(reg_imm_inst(OP_ADDI_W, 5'd0, random_reg(), 12'h123));
        issue_inst(three_reg_inst(OP_OR, random_reg(), 5'd0, 5'd0));   // r0 must read zero

        // each op reads the result just before it
        prev = random_reg();
        repeat (16) begin
            rd = random_reg();
            random_alu_op(rd, prev, prev);
            prev = rd;
        end

        repeat (6) begin
            rd = random_reg();
            issue_inst(three_reg_inst(OP_MUL_W, rd, random_reg(), random_reg()));
            random_alu_op(random_reg(), random_reg(), random_reg());
            random_alu_op(random_reg(), rd, random_reg());
        end

        // r30 holds a word-aligned base for all memory traffic
        base = word_t'($random(seed)) & 32'h7fc;
        issue_inst(reg_imm_inst(OP_ADDI_W, 5'd30, 5'd0, base[11:0]));
        repeat (8) begin
            w   = 12'($random(seed)) & 12'h3fc;
            issue_inst(reg_imm_inst(OP_ST_W, random_reg(), 5'd30, w));
            off = 12'($random(seed)) & 12'h3;
            issue_inst(reg_imm_inst(OP_ST_H, random_reg(), 5'd30, w + (off & 12'h2)));
            off = 12'($random(seed)) & 12'h3;
            issue_inst(reg_imm_inst(OP_ST_B, random_reg(), 5'd30, w + off));
            issue_inst(reg_imm_inst(OP_LD_W, random_reg(), 5'd30, w));
            issue_inst(reg_imm_inst(OP_LD_H, random_reg(), 5'd30, w + (off & 12'h2)));
            issue_inst(reg_imm_inst(OP_LD_HU, random_reg(), 5'd30, w + (off & 12'h2)));
            issue_inst(reg_imm_inst(OP_LD_B, random_reg(), 5'd30, w + off));
            issue_inst(reg_imm_inst(OP_LD_BU, random_reg(), 5'd30, w + (off ^ 12'h1)));
        end

        // misaligned accesses and then an aligned read of the same word
        repeat (4) begin
            w   = 12'($random(seed)) & 12'h3fc;
            issue_inst(reg_imm_inst(OP_ST_W, random_reg(), 5'd30, w));
            off = 12'($unsigned($random(seed)) % 3 + 1);
            issue_inst(reg_imm_inst(OP_LD_W, random_reg(), 5'd30, w + off));
            issue_inst(reg_imm_inst(OP_ST_W, random_reg(), 5'd30, w + off));
            issue_inst(reg_imm_inst(OP_LD_H, random_reg(), 5'd30, w + 12'h1));
            issue_inst(reg_imm_inst(OP_LD_HU, random_reg(), 5'd30, w + 12'h3));
            issue_inst(reg_imm_inst(OP_ST_H, random_reg(), 5'd30, w + 12'h1));
            issue_inst(reg_imm_inst(OP_LD_W, random_reg(), 5'd30, w));
        end

        repeat (3) begin
            wait_drain();   // counter only moves with the pipeline empty
            counter = {$random(seed), $random(seed)};
            issue_inst(counter_inst(OP_RDCNTVL_W, random_reg()));
            issue_inst(counter_inst(OP_RDCNTVH_W, random_reg()));
        end
        wait_drain();

        $display("%0d mismatches, %0d timeouts", mismatches, timeouts);
        if (mismatches == 0 && timeouts == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

//--- source/alu.sv
`timescale 1ns/1ps
module alu import core_pkg::*; (
    input  logic    clk,
    input  logic    resetn,
    input  logic    start,
    input  alu_op_e alu_op,
    input  word_t   alu_src1,
    input  word_t   alu_src2,
    output word_t   alu_result,
    output logic    complete
);
    typedef enum logic [1:0] {
        MUL_IDLE,
        MUL_BUSY,
        MUL_DONE
    } mul_state_e;

    mul_state_e state;
    word_t      mcand, mplier, product;
    logic [4:0] step;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state <= MUL_IDLE;
        end else begin
            case (state)
                MUL_IDLE: begin
                    if (start && alu_op == ALU_MUL) begin
                        state <= MUL_BUSY;
                    end
                end
                MUL_BUSY: begin
                    if (step == 5'd31) begin
                        state <= MUL_DONE;
                    end
                end
                MUL_DONE: begin
                    if (!start) begin   // hold result until ex lets go
                        state <= MUL_IDLE;
                    end
                end
                default: state <= MUL_IDLE;
            endcase
        end
    end

    // one shift-add step per busy cycle, low 32 bits kept
    always_ff @(posedge clk) begin
        if (state == MUL_IDLE) begin
            mcand   <= alu_src1;
            mplier  <= alu_src2;
            product <= '0;
            step    <= '0;
        end else if (state == MUL_BUSY) begin
            if (mplier[0]) begin
                product <= product + mcand;
            end
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
            step   <= step + 5'd1;
        end
    end

    always_comb begin
        case (alu_op)
            ALU_ADD: alu_result = alu_src1 + alu_src2;
            ALU_SUB: alu_result = alu_src1 - alu_src2;
            ALU_SLT: alu_result = {31'b0, $signed(alu_src1) < $signed(alu_src2)};
            ALU_AND: alu_result = alu_src1 & alu_src2;
            ALU_OR:  alu_result = alu_src1 | alu_src2;
            default: alu_result = product;
        endcase
    end

    assign complete = alu_op != ALU_MUL || state == MUL_DONE;

    assert property (@(posedge clk) disable iff (!resetn)
        state == MUL_BUSY |-> $stable(alu_op))
        else $error("alu_op changed during multiply");

endmodule

//--- source/core_pkg.sv
package core_pkg;

    typedef logic [31:0] word_t;      // data, address and pc
    typedef logic [4:0]  reg_addr_t;
    typedef logic [3:0]  byte_en_t;   // one bit per byte lane

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLT,
        ALU_AND,
        ALU_OR,
        ALU_MUL
    } alu_op_e;

    typedef enum logic [1:0] {
        SIZE_B,
        SIZE_H,
        SIZE_W
    } mem_size_e;

    // 3R format, opcode in inst[31:15]
    localparam logic [16:0] OP_ADD_W = 17'h00020;
    localparam logic [16:0] OP_SUB_W = 17'h00022;
    localparam logic [16:0] OP_SLT   = 17'h00024;
    localparam logic [16:0] OP_AND   = 17'h00029;
    localparam logic [16:0] OP_OR    = 17'h0002a;
    localparam logic [16:0] OP_MUL_W = 17'h00038;

    // 2RI12 format, opcode in inst[31:22]
    localparam logic [9:0] OP_ADDI_W = 10'h00a;
    localparam logic [9:0] OP_LD_B   = 10'h0a0;
    localparam logic [9:0] OP_LD_H   = 10'h0a1;
    localparam logic [9:0] OP_LD_W   = 10'h0a2;
    localparam logic [9:0] OP_ST_B   = 10'h0a4;
    localparam logic [9:0] OP_ST_H   = 10'h0a5;
    localparam logic [9:0] OP_ST_W   = 10'h0a6;
    localparam logic [9:0] OP_LD_BU  = 10'h0a8;
    localparam logic [9:0] OP_LD_HU  = 10'h0a9;

    // counter reads, opcode in inst[31:10] with rj zero
    localparam logic [21:0] OP_RDCNTVL_W = 22'h000018;
    localparam logic [21:0] OP_RDCNTVH_W = 22'h000019;

endpackage

//--- source/core_slice_top.sv
`timescale 1ns/1ps
module core_slice_top import core_pkg::*; #(
    parameter int RAM_WORDS = 1024
) (
    input  logic        clk,
    input  logic        resetn,
    input  logic        inst_valid,
    input  word_t       inst,
    input  word_t       inst_pc,
    output logic        inst_allowin,
    input  logic [63:0] counter,
    output logic        wb_valid,
    output word_t       wb_pc,
    output logic        wb_rf_we,
    output reg_addr_t   wb_rf_waddr,
    output word_t       wb_rf_wdata,
    output logic        wb_excep_ale
);
    // decode to execute
    logic      id_to_ex_valid, id_rf_we, id_load, id_store;
    logic      id_load_unsigned, id_read_counter, id_counter_high;
    word_t     id_pc, id_src1, id_src2, id_rkd_value;
    alu_op_e   id_alu_op;
    reg_addr_t id_rf_waddr;
    mem_size_e id_mem_size;

    // execute to memory
    logic       ex_allowin, ex_to_mem_valid, ex_rf_we, ex_load, ex_load_unsigned;
    logic       ex_excep_ale, ex_dest_valid;
    word_t      ex_pc, ex_result;
    reg_addr_t  ex_rf_waddr, ex_dest;
    mem_size_e  ex_mem_size;
    logic [1:0] ex_byte_off;

    // memory to writeback
    logic      mem_allowin, mem_to_wb_valid, mem_rf_we, mem_excep_ale, mem_dest_valid;
    word_t     mem_pc, mem_result;
    reg_addr_t mem_rf_waddr, mem_dest;
    logic      wb_allowin, wb_dest_valid;
    reg_addr_t wb_dest;

    // data RAM port
    logic     data_sram_en;
    byte_en_t data_sram_we;
    word_t    data_sram_addr, data_sram_wdata, ram_rdata;

    id_stage u_id (
        .rf_we    (wb_rf_we),
        .rf_waddr (wb_rf_waddr),
        .rf_wdata (wb_rf_wdata),
        .*
    );

    ex_stage #(.RAM_WORDS(RAM_WORDS)) u_ex (.*);

    data_ram #(.RAM_WORDS(RAM_WORDS)) u_ram (
        .clk   (clk),
        .en    (data_sram_en),
        .we    (data_sram_we),
        .addr  (data_sram_addr),
        .wdata (data_sram_wdata),
        .rdata (ram_rdata)
    );

    mem_stage u_mem (
        .rdata (ram_rdata),
        .*
    );

    wb_stage u_wb (
        .rf_we    (wb_rf_we),
        .rf_waddr (wb_rf_waddr),
        .rf_wdata (wb_rf_wdata),
        .*
    );

endmodule

//--- source/data_ram.sv
`timescale 1ns/1ps
module data_ram import core_pkg::*; #(
    parameter int RAM_WORDS = 1024
) (
    input  logic     clk,
    input  logic     en,
    input  byte_en_t we,
    input  word_t    addr,
    input  word_t    wdata,
    output word_t    rdata
);
    localparam int AW = $clog2(RAM_WORDS);

    word_t         mem [RAM_WORDS];
    logic [AW-1:0] idx;

    assign idx = addr[AW+1:2];   // byte address to word index

    always_ff @(posedge clk) begin
        if (en) begin
            rdata <= mem[idx];   // old data on a write
            for (int i = 0; i < 4; i++) begin
                if (we[i]) begin
                    mem[idx][8*i +: 8] <= wdata[8*i +: 8];
                end
            end
        end
    end

endmodule

//--- source/ex_stage.sv
`timescale 1ns/1ps
module ex_stage import core_pkg::*; #(
    parameter int RAM_WORDS = 1024
) (
    input  logic        clk,
    input  logic        resetn,
    input  logic        id_to_ex_valid,
    input  word_t       id_pc,
    input  alu_op_e     id_alu_op,
    input  word_t       id_src1,
    input  word_t       id_src2,
    input  word_t       id_rkd_value,
    input  logic        id_rf_we,
    input  reg_addr_t   id_rf_waddr,
    input  logic        id_load,
    input  logic        id_store,
    input  mem_size_e   id_mem_size,
    input  logic        id_load_unsigned,
    input  logic        id_read_counter,
    input  logic        id_counter_high,
    output logic        ex_allowin,
    input  logic        mem_allowin,
    output logic        ex_to_mem_valid,
    output word_t       ex_pc,
    output word_t       ex_result,
    output logic        ex_rf_we,
    output reg_addr_t   ex_rf_waddr,
    output logic        ex_load,
    output mem_size_e   ex_mem_size,
    output logic        ex_load_unsigned,
    output logic [1:0]  ex_byte_off,
    output logic        ex_excep_ale,
    output logic        ex_dest_valid,
    output reg_addr_t   ex_dest,
    output logic        data_sram_en,
    output byte_en_t    data_sram_we,
    output word_t       data_sram_addr,
    output word_t       data_sram_wdata,
    input  logic [63:0] counter
);
    logic     ex_valid, alu_complete, mem_fire, mem_op;
    logic     rf_we_r, store_r, read_counter_r, counter_high_r;
    alu_op_e  alu_op_r;
    word_t    src1_r, src2_r, rkd_r, alu_result;
    byte_en_t byte_en;

    assign ex_allowin      = !ex_valid || (alu_complete && mem_allowin);
    assign ex_to_mem_valid = ex_valid && alu_complete;
    assign mem_fire        = ex_to_mem_valid && mem_allowin;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            ex_valid <= 1'b0;
        end else if (ex_allowin) begin
            ex_valid <= id_to_ex_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (id_to_ex_valid && ex_allowin) begin
            ex_pc            <= id_pc;
            alu_op_r         <= id_alu_op;
            src1_r           <= id_src1;
            src2_r           <= id_src2;
            rkd_r            <= id_rkd_value;
            rf_we_r          <= id_rf_we;
            ex_rf_waddr      <= id_rf_waddr;
            ex_load          <= id_load;
            store_r          <= id_store;
            ex_mem_size      <= id_mem_size;
            ex_load_unsigned <= id_load_unsigned;
            read_counter_r   <= id_read_counter;
            counter_high_r   <= id_counter_high;
        end
    end

    alu u_alu (
        .clk        (clk),
        .resetn     (resetn),
        .start      (ex_valid && !mem_fire),   // drops as the op leaves ex
        .alu_op     (alu_op_r),
        .alu_src1   (src1_r),
        .alu_src2   (src2_r),
        .alu_result (alu_result),
        .complete   (alu_complete)
    );

    assign ex_result = !read_counter_r ? alu_result :
                       counter_high_r  ? counter[63:32] : counter[31:0];
    assign ex_byte_off = alu_result[1:0];

    assign mem_op       = ex_load || store_r;
    assign ex_excep_ale = mem_op && ((ex_mem_size == SIZE_H && alu_result[0]) ||
                                     (ex_mem_size == SIZE_W && alu_result[1:0] != 2'b00));
    assign ex_rf_we      = rf_we_r && !ex_excep_ale;
    assign ex_dest_valid = ex_valid && ex_rf_we;
    assign ex_dest       = ex_rf_waddr;

    always_comb begin
        case (ex_mem_size)
            SIZE_B:  byte_en = 4'b0001 << alu_result[1:0];
            SIZE_H:  byte_en = alu_result[1] ? 4'b1100 : 4'b0011;
            default: byte_en = 4'b1111;
        endcase
    end

    // address goes out a cycle early, data lands in mem
    assign data_sram_en    = mem_fire && mem_op && !ex_excep_ale;
    assign data_sram_we    = (data_sram_en && store_r) ? byte_en : '0;
    assign data_sram_addr  = alu_result;
    assign data_sram_wdata = (ex_mem_size == SIZE_B) ? {4{rkd_r[7:0]}} :
                             (ex_mem_size == SIZE_H) ? {2{rkd_r[15:0]}} : rkd_r;

    assert property (@(posedge clk) disable iff (!resetn)
        data_sram_en |-> data_sram_addr[31:2] < RAM_WORDS)
        else $error("data access %h beyond RAM", data_sram_addr);

endmodule

//--- source/id_stage.sv
`timescale 1ns/1ps
module id_stage import core_pkg::*; (
    input  logic      clk,
    input  logic      resetn,
    input  logic      inst_valid,
    input  word_t     inst,
    input  word_t     inst_pc,
    output logic      inst_allowin,
    input  logic      ex_allowin,
    output logic      id_to_ex_valid,
    output word_t     id_pc,
    output alu_op_e   id_alu_op,
    output word_t     id_src1,
    output word_t     id_src2,
    output word_t     id_rkd_value,
    output logic      id_rf_we,
    output reg_addr_t id_rf_waddr,
    output logic      id_load,
    output logic      id_store,
    output mem_size_e id_mem_size,
    output logic      id_load_unsigned,
    output logic      id_read_counter,
    output logic      id_counter_high,
    input  logic      ex_dest_valid,
    input  reg_addr_t ex_dest,
    input  logic      mem_dest_valid,
    input  reg_addr_t mem_dest,
    input  logic      wb_dest_valid,
    input  reg_addr_t wb_dest,
    input  logic      rf_we,
    input  reg_addr_t rf_waddr,
    input  word_t     rf_wdata
);
    logic        id_valid;
    word_t       id_inst;
    logic        hazard;
    logic [16:0] op3r;
    logic [9:0]  op12;
    reg_addr_t   rd, rj, rk, raddr2;
    logic        is_add, is_sub, is_slt, is_and, is_or, is_mul, is_3r, is_addi;
    logic        is_ld_b, is_ld_h, is_ld_w, is_ld_bu, is_ld_hu, is_st_b, is_st_h, is_st_w;
    logic        is_cnt_l, is_cnt_h, inst_known;
    word_t       rdata1, rdata2, imm12;
    word_t       rf [32];

    assign inst_allowin   = !id_valid || (!hazard && ex_allowin);
    assign id_to_ex_valid = id_valid && !hazard;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            id_valid <= 1'b0;
        end else if (inst_allowin) begin
            id_valid <= inst_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (inst_valid && inst_allowin) begin
            id_inst <= inst;
            id_pc   <= inst_pc;
        end
    end

    assign op3r = id_inst[31:15];
    assign op12 = id_inst[31:22];
    assign rd   = id_inst[4:0];
    assign rj   = id_inst[9:5];
    assign rk   = id_inst[14:10];

    assign is_add   = op3r == OP_ADD_W;
    assign is_sub   = op3r == OP_SUB_W;
    assign is_slt   = op3r == OP_SLT;
    assign is_and   = op3r == OP_AND;
    assign is_or    = op3r == OP_OR;
    assign is_mul   = op3r == OP_MUL_W;
    assign is_addi  = op12 == OP_ADDI_W;
    assign is_ld_b  = op12 == OP_LD_B;
    assign is_ld_h  = op12 == OP_LD_H;
    assign is_ld_w  = op12 == OP_LD_W;
    assign is_ld_bu = op12 == OP_LD_BU;
    assign is_ld_hu = op12 == OP_LD_HU;
    assign is_st_b  = op12 == OP_ST_B;
    assign is_st_h  = op12 == OP_ST_H;
    assign is_st_w  = op12 == OP_ST_W;
    assign is_cnt_l = id_inst[31:10] == OP_RDCNTVL_W && rj == '0;
    assign is_cnt_h = id_inst[31:10] == OP_RDCNTVH_W && rj == '0;

    assign is_3r            = is_add | is_sub | is_slt | is_and | is_or | is_mul;
    assign id_load          = is_ld_b | is_ld_h | is_ld_w | is_ld_bu | is_ld_hu;
    assign id_store         = is_st_b | is_st_h | is_st_w;
    assign id_load_unsigned = is_ld_bu | is_ld_hu;
    assign id_read_counter  = is_cnt_l | is_cnt_h;
    assign id_counter_high  = is_cnt_h;
    assign inst_known       = is_3r | is_addi | id_load | id_store | id_read_counter;

    assign id_mem_size = (is_ld_b | is_ld_bu | is_st_b) ? SIZE_B :
                         (is_ld_h | is_ld_hu | is_st_h) ? SIZE_H : SIZE_W;
    assign id_alu_op   = is_sub ? ALU_SUB :
                         is_slt ? ALU_SLT :
                         is_and ? ALU_AND :
                         is_or  ? ALU_OR  :
                         is_mul ? ALU_MUL : ALU_ADD;   // loads and stores add too

    assign id_rf_we    = is_3r | is_addi | id_load | id_read_counter;
    assign id_rf_waddr = rd;

    // stores read rd as data on the second port
    assign raddr2 = id_store ? rd : rk;
    assign rdata1 = (rj == '0) ? '0 : (rf_we && rf_waddr == rj) ? rf_wdata : rf[rj];
    assign rdata2 = (raddr2 == '0) ? '0 : (rf_we && rf_waddr == raddr2) ? rf_wdata : rf[raddr2];
    assign imm12  = {{20{id_inst[21]}}, id_inst[21:10]};

    assign id_src1      = rdata1;
    assign id_src2      = is_3r ? rdata2 : imm12;
    assign id_rkd_value = rdata2;

    always_ff @(posedge clk) begin
        if (rf_we) begin
            rf[rf_waddr] <= rf_wdata;
        end
    end

    // no forwarding, so wait for every older writer to leave
    function automatic logic in_flight(reg_addr_t r);
        return r != '0 && ((ex_dest_valid && ex_dest == r) ||
                           (mem_dest_valid && mem_dest == r) ||
                           (wb_dest_valid && wb_dest == r));
    endfunction

    always_comb begin
        hazard = in_flight(rj) || ((is_3r || id_store) && in_flight(raddr2));
    end

    assert property (@(posedge clk) disable iff (!resetn) id_valid |-> inst_known)
        else $error("unknown opcode %h in decode", id_inst);

endmodule

//--- source/mem_stage.sv
`timescale 1ns/1ps
module mem_stage import core_pkg::*; (
    input  logic       clk,
    input  logic       resetn,
    input  logic       ex_to_mem_valid,
    input  word_t      ex_pc,
    input  word_t      ex_result,
    input  logic       ex_rf_we,
    input  reg_addr_t  ex_rf_waddr,
    input  logic       ex_load,
    input  mem_size_e  ex_mem_size,
    input  logic       ex_load_unsigned,
    input  logic [1:0] ex_byte_off,
    input  logic       ex_excep_ale,
    output logic       mem_allowin,
    input  logic       wb_allowin,
    input  word_t      rdata,
    output logic       mem_to_wb_valid,
    output word_t      mem_pc,
    output logic       mem_rf_we,
    output reg_addr_t  mem_rf_waddr,
    output word_t      mem_result,
    output logic       mem_excep_ale,
    output logic       mem_dest_valid,
    output reg_addr_t  mem_dest
);
    logic       mem_valid, mem_load, mem_load_unsigned;
    mem_size_e  mem_size;
    logic [1:0] mem_byte_off;
    word_t      ex_result_r, load_data;
    logic [7:0] load_byte;
    logic [15:0] load_half;

    assign mem_allowin     = !mem_valid || wb_allowin;   // one cycle here
    assign mem_to_wb_valid = mem_valid;
    assign mem_dest_valid  = mem_valid && mem_rf_we;
    assign mem_dest        = mem_rf_waddr;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            mem_valid <= 1'b0;
        end else if (mem_allowin) begin
            mem_valid <= ex_to_mem_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (ex_to_mem_valid && mem_allowin) begin
            mem_pc            <= ex_pc;
            ex_result_r       <= ex_result;
            mem_rf_we         <= ex_rf_we;
            mem_rf_waddr      <= ex_rf_waddr;
            mem_load          <= ex_load;
            mem_size          <= ex_mem_size;
            mem_load_unsigned <= ex_load_unsigned;
            mem_byte_off      <= ex_byte_off;
            mem_excep_ale     <= ex_excep_ale;
        end
    end

    assign load_byte = rdata[{mem_byte_off, 3'b000} +: 8];
    assign load_half = rdata[{mem_byte_off[1], 4'b0000} +: 16];

    always_comb begin
        case (mem_size)
            SIZE_B:  load_data = {{24{load_byte[7] && !mem_load_unsigned}}, load_byte};
            SIZE_H:  load_data = {{16{load_half[15] && !mem_load_unsigned}}, load_half};
            default: load_data = rdata;
        endcase
    end

    assign mem_result = (mem_load && !mem_excep_ale) ? load_data : ex_result_r;

endmodule

//--- source/wb_stage.sv
`timescale 1ns/1ps
module wb_stage import core_pkg::*; (
    input  logic      clk,
    input  logic      resetn,
    input  logic      mem_to_wb_valid,
    input  word_t     mem_pc,
    input  logic      mem_rf_we,
    input  reg_addr_t mem_rf_waddr,
    input  word_t     mem_result,
    input  logic      mem_excep_ale,
    output logic      wb_allowin,
    output logic      rf_we,
    output reg_addr_t rf_waddr,
    output word_t     rf_wdata,
    output logic      wb_valid,
    output word_t     wb_pc,
    output logic      wb_excep_ale,
    output logic      wb_dest_valid,
    output reg_addr_t wb_dest
);
    logic wb_rf_we_r;

    assign wb_allowin = 1'b1;   // retires every cycle

    always_ff @(posedge clk) begin
        if (!resetn) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= mem_to_wb_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (mem_to_wb_valid) begin
            wb_pc        <= mem_pc;
            wb_rf_we_r   <= mem_rf_we;
            rf_waddr     <= mem_rf_waddr;
            rf_wdata     <= mem_result;
            wb_excep_ale <= mem_excep_ale;
        end
    end

    assign rf_we         = wb_valid && wb_rf_we_r && !wb_excep_ale;
    assign wb_dest_valid = rf_we;
    assign wb_dest       = rf_waddr;

endmodule
